// ==== common/fm_pkg.sv ====
package fm_pkg;

    // Bus and slot indices
    typedef logic [7:0]  addr_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  slot_t;
    typedef logic [4:0]  chan_t;

    // Voice datapath
    typedef logic [9:0]         phase_t;
    typedef logic [8:0]         env_t;
    typedef logic signed [12:0] sample_t;

    // Field widths
    localparam int FNUM_W   = 10;
    localparam int BLOCK_W  = 3;
    localparam int MULT_W   = 4;
    localparam int RATE_W   = 4;
    localparam int TL_W     = 6;
    localparam int WS_W     = 3;
    localparam int PH_ACC_W = 19;

    // Address map
    localparam addr_t ADDR_4OP   = 8'h00;
    localparam addr_t ADDR_FLAGS = 8'h01;
    localparam addr_t CH_BASE    = 8'h60;
    localparam addr_t OP_BASE    = 8'h80;

    localparam int SLOT_CYCLES = 4;
    localparam int NUM_SLOTS   = 64;

    typedef enum logic [1:0] {
        st_log_sin,
        st_exp,
        st_result,
        st_done
    } seq_state_t;

    typedef enum logic [1:0] {
        eg_attack,
        eg_decay,
        eg_sustain,
        eg_release
    } eg_state_t;

    // Waveform select codes
    localparam logic [WS_W-1:0] ws_sine    = 3'd0;
    localparam logic [WS_W-1:0] ws_half    = 3'd1;
    localparam logic [WS_W-1:0] ws_abs     = 3'd2;
    localparam logic [WS_W-1:0] ws_quarter = 3'd3;

endpackage

// ==== compile.f ====
+incdir+testbench
common/fm_pkg.sv
design/fm_op_attr.sv
design/fm_ch_attr.sv
voice/fm_phase.sv
voice/fm_eg.sv
voice/fm_op.sv
design/fmsynth.sv
testbench/tb_fmsynth.sv

// ==== design/fm_ch_attr.sv ====
`timescale 1ns/1ps

module fm_ch_attr (
    input  logic                            clk,
    input  logic [4:0]                      addr,
    input  fm_pkg::word_t                   wrdata,
    input  logic                            wren,
    output fm_pkg::word_t                   rddata,

    input  fm_pkg::chan_t                   ch_sel,
    output logic                            ch_chb,
    output logic                            ch_cha,
    output logic [2:0]                      ch_fb,
    output logic                            ch_cnt,
    output logic                            ch_kon,
    output logic [fm_pkg::BLOCK_W-1:0]      ch_block,
    output logic [fm_pkg::FNUM_W-1:0]       ch_fnum
);
    import fm_pkg::*;

    // Packed as {chb, cha, fb, cnt, kon, block, fnum}
    logic [19:0] ch_mem [NUM_SLOTS/2];
    logic [19:0] rd_word;
    logic [19:0] sel_word;

    always_ff @(posedge clk) begin
        if (wren)
            ch_mem[addr] <= {wrdata[21:16], wrdata[13:0]};
    end

    // Bus view puts the upper fields back at bit 16
    assign rd_word  = ch_mem[addr];
    assign rddata   = {10'b0, rd_word[19:14], 2'b0, rd_word[13:0]};

    assign sel_word = ch_mem[ch_sel];
    assign ch_fnum  = sel_word[9:0];
    assign ch_block = sel_word[12:10];
    assign ch_kon   = sel_word[13];
    assign ch_cnt   = sel_word[14];
    assign ch_fb    = sel_word[17:15];
    assign ch_cha   = sel_word[18];
    assign ch_chb   = sel_word[19];

endmodule

// ==== design/fm_op_attr.sv ====
`timescale 1ns/1ps

module fm_op_attr (
    input  logic                            clk,
    input  logic [6:0]                      addr,
    input  fm_pkg::word_t                   wrdata,
    input  logic                            wren,
    output fm_pkg::word_t                   rddata,

    input  fm_pkg::slot_t                   op_sel,
    output logic [fm_pkg::WS_W-1:0]         op_ws,
    output logic                            op_am,
    output logic                            op_vib,
    output logic                            op_egt,
    output logic                            op_ksr,
    output logic [fm_pkg::MULT_W-1:0]       op_mult,
    output logic [1:0]                      op_ksl,
    output logic [fm_pkg::TL_W-1:0]         op_tl,
    output logic [fm_pkg::RATE_W-1:0]       op_ar,
    output logic [fm_pkg::RATE_W-1:0]       op_dr,
    output logic [fm_pkg::RATE_W-1:0]       op_sl,
    output logic [fm_pkg::RATE_W-1:0]       op_rr
);
    import fm_pkg::*;

    // Word 0 keeps ws..mult, word 1 keeps ksl..rr
    logic [10:0] w0_mem [NUM_SLOTS];
    logic [23:0] w1_mem [NUM_SLOTS];
    logic [10:0] w0_sel;
    logic [23:0] w1_sel;

    always_ff @(posedge clk) begin
        if (wren) begin
            if (addr[0])
                w1_mem[addr[6:1]] <= wrdata[23:0];
            else
                w0_mem[addr[6:1]] <= wrdata[10:0];
        end
    end

    assign rddata = addr[0] ? {8'b0, w1_mem[addr[6:1]]} : {21'b0, w0_mem[addr[6:1]]};

    // Slot side decode
    assign w0_sel  = w0_mem[op_sel];
    assign w1_sel  = w1_mem[op_sel];

    assign op_ws   = w0_sel[10:8];
    assign op_am   = w0_sel[7];
    assign op_vib  = w0_sel[6];
    assign op_egt  = w0_sel[5];
    assign op_ksr  = w0_sel[4];
    assign op_mult = w0_sel[3:0];
    assign op_ksl  = w1_sel[23:22];
    assign op_tl   = w1_sel[21:16];
    assign op_ar   = w1_sel[15:12];
    assign op_dr   = w1_sel[11:8];
    assign op_sl   = w1_sel[7:4];
    assign op_rr   = w1_sel[3:0];

    a_fields_known: assert property (@(posedge clk)
        !$isunknown(op_sel) |-> !$isunknown({w0_sel, w1_sel}))
        else $error("operator %0d presents unknown fields", op_sel);

endmodule

// ==== design/fmsynth.sv ====
`timescale 1ns/1ps

module fmsynth (
    input  logic                clk,
    input  logic                reset,
    input  fm_pkg::addr_t       addr,
    input  fm_pkg::word_t       wrdata,
    input  logic                wren,
    output fm_pkg::word_t       rddata,
    output logic [15:0]         audio_l,
    output logic [15:0]         audio_r
);
    import fm_pkg::*;

    logic        q_dam;
    logic        q_dvb;
    logic        q_nts;
    logic [15:0] q_4op;
    word_t       ch_rddata;
    word_t       op_rddata;
    logic        sel_reg0;
    logic        sel_reg1;
    logic        sel_ch;
    logic        sel_op;

    slot_t       op_sel;
    logic        next;
    seq_state_t  state;
    sample_t     result;
    sample_t     q_result;
    sample_t     sat_sum;
    logic signed [18:0] acc;

    logic [WS_W-1:0]    op_ws;
    logic               op_egt;
    logic [MULT_W-1:0]  op_mult;
    logic [TL_W-1:0]    op_tl;
    logic [RATE_W-1:0]  op_ar;
    logic [RATE_W-1:0]  op_dr;
    logic [RATE_W-1:0]  op_sl;
    logic [RATE_W-1:0]  op_rr;
    logic               ch_kon;
    logic [BLOCK_W-1:0] ch_block;
    logic [FNUM_W-1:0]  ch_fnum;
    phase_t             phase;
    env_t               env;

    ////////////////////////////////////////
    // Global registers and read mux
    ////////////////////////////////////////
    assign sel_reg0 = addr == ADDR_4OP;
    assign sel_reg1 = addr == ADDR_FLAGS;
    assign sel_ch   = addr[7:5] == CH_BASE[7:5];
    assign sel_op   = addr[7] == OP_BASE[7];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_4op <= '0;
            q_nts <= 1'b0;
            q_dam <= 1'b0;
            q_dvb <= 1'b0;
        end else if (wren) begin
            if (sel_reg0)
                q_4op <= wrdata[15:0];
            if (sel_reg1) begin
                q_nts <= wrdata[14];
                q_dam <= wrdata[7];
                q_dvb <= wrdata[6];
            end
        end
    end

    always_comb begin
        rddata = '0;
        if (sel_reg0)
            rddata = {16'b0, q_4op};
        else if (sel_reg1)
            rddata = {17'b0, q_nts, 6'b0, q_dam, q_dvb, 6'b0};
        else if (sel_ch)
            rddata = ch_rddata;
        else if (sel_op)
            rddata = op_rddata;
    end

    // am, vib, ksr, ksl and the channel mode bits are stored only
    fm_op_attr i_op_attr (
        .clk(clk), .addr(addr[6:0]), .wrdata(wrdata), .wren(sel_op && wren),
        .rddata(op_rddata), .op_sel(op_sel), .op_ws(op_ws), .op_am(), .op_vib(),
        .op_egt(op_egt), .op_ksr(), .op_mult(op_mult), .op_ksl(), .op_tl(op_tl),
        .op_ar(op_ar), .op_dr(op_dr), .op_sl(op_sl), .op_rr(op_rr)
    );

    fm_ch_attr i_ch_attr (
        .clk(clk), .addr(addr[4:0]), .wrdata(wrdata), .wren(sel_ch && wren),
        .rddata(ch_rddata), .ch_sel(op_sel[5:1]), .ch_chb(), .ch_cha(), .ch_fb(),
        .ch_cnt(), .ch_kon(ch_kon), .ch_block(ch_block), .ch_fnum(ch_fnum)
    );

    fm_phase i_phase (
        .clk(clk), .reset(reset), .op_sel(op_sel), .next(next),
        .block(ch_block), .fnum(ch_fnum), .mult(op_mult), .phase(phase)
    );

    fm_eg i_eg (
        .clk(clk), .reset(reset), .op_sel(op_sel), .next(next), .ar(op_ar),
        .dr(op_dr), .sl(op_sl), .rr(op_rr), .tl(op_tl), .kon(ch_kon),
        .egt(op_egt), .env(env)
    );

    fm_op i_op (.clk(clk), .ws(op_ws), .phase(phase), .env(env), .result(result));

    ////////////////////////////////////////
    // Slot sequencer and frame mixer
    ////////////////////////////////////////
    always_comb begin
        if (acc > 19'sd4095)
            sat_sum = 13'sd4095;
        else if (acc < -19'sd4096)
            sat_sum = -13'sd4096;
        else
            sat_sum = acc[12:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_log_sin;
            op_sel   <= '0;
            next     <= 1'b0;
            acc      <= '0;
            q_result <= '0;
        end else begin
            next <= 1'b0;
            case (state)
                st_log_sin: state <= st_exp;
                st_exp:     state <= st_result;
                st_result: begin
                    acc   <= acc + {{6{result[12]}}, result};
                    next  <= 1'b1;
                    state <= st_done;
                end
                default: begin
                    // Last slot closes the frame
                    if (op_sel == slot_t'(NUM_SLOTS - 1)) begin
                        q_result <= sat_sum;
                        acc      <= '0;
                    end
                    op_sel <= op_sel + 6'd1;
                    state  <= st_log_sin;
                end
            endcase
        end
    end

    assign audio_l = {q_result, 3'b000};
    assign audio_r = {q_result, 3'b000};

    a_next_period: assert property (@(posedge clk) disable iff (reset)
        next |=> !next [*(SLOT_CYCLES - 1)] ##1 next)
        else $error("slot update pulse out of step");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fmsynth testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_fmsynth -f compile.f -o tb_fmsynth_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fmsynth_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    echo "Result: passed"
    exit 0
else
    echo "Result: failed"
    exit 1
fi

// ==== testbench/tb_fmsynth_cases.svh ====
`ifndef TB_FMSYNTH_CASES_SVH
`define TB_FMSYNTH_CASES_SVH

localparam int NUM_CASES = 16;

// Field masks per address region
localparam word_t MASK_4OP   = 32'h0000_ffff;
localparam word_t MASK_FLAGS = 32'h0000_40c0;
localparam word_t MASK_CH    = 32'h003f_3fff;
localparam word_t MASK_OP_W0 = 32'h0000_07ff;
localparam word_t MASK_OP_W1 = 32'h00ff_ffff;

string case_name [NUM_CASES];
addr_t case_addr [NUM_CASES];
word_t case_data [NUM_CASES];
word_t case_mask [NUM_CASES];
bit    case_rand [NUM_CASES];
int    n_loaded;

// Test voice on channel 0, operator 1 is the audible one
localparam addr_t VOICE_CH      = 8'h60;
localparam addr_t VOICE_OP_W0   = 8'h82;
localparam addr_t VOICE_OP_W1   = 8'h83;
localparam word_t VOICE_KEY_ON  = 32'h0000_3fff;
localparam word_t VOICE_KEY_OFF = 32'h0000_1fff;
localparam word_t VOICE_SINE    = 32'h0000_0021;
localparam word_t VOICE_HALF    = 32'h0000_0121;
localparam word_t VOICE_RATES   = 32'h0000_f00f;
// tl 63 and rr 15 keep every other operator silent
localparam word_t QUIET_RATES   = 32'h003f_000f;

task automatic add_case(string name, addr_t a, word_t d, word_t m, bit r);
    case_name[n_loaded] = name;
    case_addr[n_loaded] = a;
    case_data[n_loaded] = d;
    case_mask[n_loaded] = m;
    case_rand[n_loaded] = r;
    n_loaded++;
endtask

// Columns: name, address, write data, readback mask, random data
task automatic load_cases();
    n_loaded = 0;
    add_case("reg_4op",        8'h00, 32'h0,        MASK_4OP,   1'b1);
    add_case("reg_flags",      8'h01, 32'h0,        MASK_FLAGS, 1'b1);
    add_case("reg_flags_ones", 8'h01, 32'hffffffff, MASK_FLAGS, 1'b0);
    add_case("ch_first",       8'h60, 32'h0,        MASK_CH,    1'b1);
    add_case("ch_mid",         8'h6d, 32'h0,        MASK_CH,    1'b1);
    add_case("ch_last",        8'h7f, 32'h0,        MASK_CH,    1'b1);
    add_case("ch_ones",        8'h61, 32'hffffffff, MASK_CH,    1'b0);
    add_case("op0_w0",         8'h80, 32'h0,        MASK_OP_W0, 1'b1);
    add_case("op0_w1",         8'h81, 32'h0,        MASK_OP_W1, 1'b1);
    add_case("op19_w0",        8'ha6, 32'h0,        MASK_OP_W0, 1'b1);
    add_case("op36_w1",        8'hc9, 32'h0,        MASK_OP_W1, 1'b1);
    add_case("op63_w0",        8'hfe, 32'h0,        MASK_OP_W0, 1'b1);
    add_case("op63_w1_ones",   8'hff, 32'hffffffff, MASK_OP_W1, 1'b0);
    add_case("gap_low",        8'h02, 32'h0,        32'h0,      1'b1);
    add_case("gap_mid_ones",   8'h40, 32'hffffffff, 32'h0,      1'b0);
    add_case("gap_high",       8'h5f, 32'h0,        32'h0,      1'b1);
endtask

`endif

// ==== testbench/tb_fmsynth.sv ====
`timescale 1ns/1ps

module tb_fmsynth;
    import fm_pkg::*;

    `include "tb_fmsynth_cases.svh"

    localparam int SEED         = 63183;
    localparam int RESET_CYCLES = 4;
    localparam int FRAME_CYCLES = SLOT_CYCLES * NUM_SLOTS;

    // Frame counts of the audio scenarios
    localparam int IDLE_FRAMES    = 2;
    localparam int KEYON_FRAMES   = 2;
    localparam int SINE_FRAMES    = 5;
    localparam int SETTLE_FRAMES  = 2;
    localparam int HALF_FRAMES    = 16;
    localparam int RELEASE_FRAMES = 3;
    localparam int AUDIO_FRAMES   = IDLE_FRAMES + KEYON_FRAMES + SINE_FRAMES
                                  + SETTLE_FRAMES + HALF_FRAMES + RELEASE_FRAMES + 1;

    // Rows take about 4 cycles, each clearing write 2
    localparam int TIMEOUT_CYCLES = NUM_CASES * 4 + 160 * 2 + 4 * RESET_CYCLES
                                  + (AUDIO_FRAMES + 2) * FRAME_CYCLES;

    logic        clk;
    logic        reset;
    addr_t       addr;
    word_t       wrdata;
    logic        wren;
    word_t       rddata;
    logic [15:0] audio_l;
    logic [15:0] audio_r;

    int cycles;
    bit seen_nonzero;
    bit seen_negative;
    bit forbid_negative;

    fmsynth i_fmsynth (
        .clk(clk), .reset(reset), .addr(addr), .wrdata(wrdata), .wren(wren),
        .rddata(rddata), .audio_l(audio_l), .audio_r(audio_r)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Bus and check tasks
    ////////////////////////////////////////
    task automatic check(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic write_word(addr_t a, word_t d);
        @(posedge clk);
        #1;
        addr   = a;
        wrdata = d;
        wren   = 1'b1;
        @(posedge clk);
        #1;
        wren   = 1'b0;
    endtask

    task automatic read_word(addr_t a, output word_t d);
        @(posedge clk);
        #1;
        addr = a;
        wren = 1'b0;
        @(negedge clk);
        d = rddata;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // All channels keyed off, all operators silent
    task automatic clear_stores();
        for (int i = 0; i < NUM_SLOTS / 2; i++)
            write_word(addr_t'(int'(CH_BASE) + i), '0);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            write_word(addr_t'(int'(OP_BASE) + 2 * i), '0);
            write_word(addr_t'(int'(OP_BASE) + 2 * i + 1), QUIET_RATES);
        end
    endtask

    task automatic clear_flags();
        seen_nonzero  = 1'b0;
        seen_negative = 1'b0;
    endtask

    // Both channels must match and keep their low bits clear
    task automatic watch_frames(int frames, string label);
        int n;
        n = frames * FRAME_CYCLES;
        for (int c = 0; c < n; c++) begin
            @(negedge clk);
            check({label, "_lr"}, 32'(audio_l), 32'(audio_r));
            check({label, "_low_bits"}, 32'h0, 32'(audio_l[2:0]));
            if (audio_l != 16'h0)
                seen_nonzero = 1'b1;
            if (audio_l[15])
                seen_negative = 1'b1;
            if (forbid_negative)
                check({label, "_sign"}, 32'h0, 32'(audio_l[15]));
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        word_t data;
        word_t got;

        reset           = 1'b1;
        addr            = '0;
        wrdata          = '0;
        wren            = 1'b0;
        forbid_negative = 1'b0;
        clear_flags();
        void'($urandom(SEED));
        load_cases();
        check("case_count", 32'(NUM_CASES), 32'(n_loaded));

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register readback
        for (int i = 0; i < NUM_CASES; i++) begin
            data = case_rand[i] ? $urandom : case_data[i];
            write_word(case_addr[i], data);
            read_word(case_addr[i], got);
            check(case_name[i], data & case_mask[i], got);
        end

        clear_stores();
        apply_reset();

        // Idle, nothing keyed on
        clear_flags();
        watch_frames(IDLE_FRAMES, "idle");
        check("idle_silent", 32'h0, 32'(seen_nonzero));

        // Sine carrier keyed on
        write_word(VOICE_OP_W0, VOICE_SINE);
        write_word(VOICE_OP_W1, VOICE_RATES);
        write_word(VOICE_CH, VOICE_KEY_ON);
        clear_flags();
        watch_frames(KEYON_FRAMES, "key_on");
        check("key_on_sound", 32'h1, 32'(seen_nonzero));
        watch_frames(SINE_FRAMES, "sine");
        check("sine_negative", 32'h1, 32'(seen_negative));

        // Half sine never goes below zero
        write_word(VOICE_OP_W0, VOICE_HALF);
        watch_frames(SETTLE_FRAMES, "half_settle");
        clear_flags();
        forbid_negative = 1'b1;
        watch_frames(HALF_FRAMES, "half");
        forbid_negative = 1'b0;
        check("half_sound", 32'h1, 32'(seen_nonzero));

        // Key off with fast release
        write_word(VOICE_CH, VOICE_KEY_OFF);
        watch_frames(RELEASE_FRAMES, "release");
        check("release_silent", 32'h0, 32'(audio_l));
        clear_flags();
        watch_frames(1, "after_release");
        check("after_release_silent", 32'h0, 32'(seen_nonzero));

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

// ==== voice/fm_eg.sv ====
`timescale 1ns/1ps

module fm_eg (
    input  logic                            clk,
    input  logic                            reset,
    input  fm_pkg::slot_t                   op_sel,
    input  logic                            next,
    input  logic [fm_pkg::RATE_W-1:0]       ar,
    input  logic [fm_pkg::RATE_W-1:0]       dr,
    input  logic [fm_pkg::RATE_W-1:0]       sl,
    input  logic [fm_pkg::RATE_W-1:0]       rr,
    input  logic [fm_pkg::TL_W-1:0]         tl,
    input  logic                            kon,
    input  logic                            egt,
    output fm_pkg::env_t                    env
);
    import fm_pkg::*;

    env_t      att_mem [NUM_SLOTS];
    eg_state_t st_mem  [NUM_SLOTS];
    logic      kon_mem [NUM_SLOTS];

    env_t      att;
    eg_state_t st_cur;
    eg_state_t st_nxt;
    logic [9:0] att_nxt;
    logic [9:0] sum;
    logic [9:0] sl_lvl;
    logic [9:0] env_sum;

    assign att    = att_mem[op_sel];
    assign sl_lvl = {1'b0, sl, 5'b0};

    always_comb begin
        // Key edges override the stored state
        st_cur = st_mem[op_sel];
        if (kon && !kon_mem[op_sel])
            st_cur = eg_attack;
        else if (!kon && kon_mem[op_sel])
            st_cur = eg_release;

        st_nxt  = st_cur;
        att_nxt = {1'b0, att};
        sum     = '0;
        case (st_cur)
            eg_attack: begin
                if (ar == 4'hf || att <= env_t'(ar)) begin
                    att_nxt = '0;
                    st_nxt  = eg_decay;
                end else begin
                    att_nxt = {1'b0, att} - 10'(ar);
                end
            end
            eg_decay: begin
                sum = {1'b0, att} + 10'(dr);
                if (sum >= sl_lvl) begin
                    att_nxt = sl_lvl;
                    st_nxt  = egt ? eg_sustain : eg_release;
                end else begin
                    att_nxt = sum;
                end
            end
            eg_sustain: att_nxt = {1'b0, att};
            default: begin
                sum = {1'b0, att} + 10'(rr);
                if (rr == 4'hf || sum > 10'd511)
                    att_nxt = 10'd511;
                else
                    att_nxt = sum;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                att_mem[i] <= 9'd511;
                st_mem[i]  <= eg_release;
                kon_mem[i] <= 1'b0;
            end
        end else if (next) begin
            att_mem[op_sel] <= att_nxt[8:0];
            st_mem[op_sel]  <= st_nxt;
            kon_mem[op_sel] <= kon;
        end
    end

    // Total level adds 0.75 dB per step, clamp at silence
    assign env_sum = {1'b0, att} + {2'b0, tl, 2'b0};
    assign env     = env_sum[9] ? 9'd511 : env_sum[8:0];

    a_att_range: assert property (@(posedge clk) disable iff (reset)
        next |-> att_nxt <= 10'd511)
        else $error("envelope update overflows for slot %0d", op_sel);

endmodule

// ==== voice/fm_op.sv ====
`timescale 1ns/1ps

module fm_op (
    input  logic                        clk,
    input  logic [fm_pkg::WS_W-1:0]     ws,
    input  fm_pkg::phase_t              phase,
    input  fm_pkg::env_t                env,
    output fm_pkg::sample_t             result
);
    import fm_pkg::*;

    logic        neg_half;
    logic        odd_quad;
    logic [7:0]  x;
    logic [16:0] para;
    logic [11:0] mag_sin;
    logic [11:0] mag_wave;
    logic        sign;
    logic [11:0] mag_shift;
    logic [18:0] mag_scaled;
    logic [11:0] mag_att;

    ////////////////////////////////////////
    // Quarter-wave sine
    ////////////////////////////////////////
    assign neg_half = phase[9];
    assign odd_quad = phase[8];

    // Falling quarters run the index backwards
    assign x = odd_quad ? ~phase[7:0] : phase[7:0];

    // x*(512-x)/16 peaks at 4095 near x = 255
    assign para    = 17'(x) * (17'd512 - 17'(x));
    assign mag_sin = para[15:4];

    ////////////////////////////////////////
    // Waveform select
    ////////////////////////////////////////
    always_comb begin
        mag_wave = mag_sin;
        sign     = neg_half;
        case (ws)
            ws_half: begin
                sign = 1'b0;
                if (neg_half)
                    mag_wave = '0;
            end
            ws_abs: sign = 1'b0;
            ws_quarter: begin
                sign = 1'b0;
                if (odd_quad)
                    mag_wave = '0;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Attenuation
    ////////////////////////////////////////
    // Top bits halve per step, low bits scale from 1 down to about 1/2
    assign mag_shift  = mag_wave >> env[8:5];
    assign mag_scaled = 19'(mag_shift) * (19'd64 - 19'(env[4:0]));
    assign mag_att    = mag_scaled[17:6];

    always_ff @(posedge clk) begin
        if (sign)
            result <= -sample_t'({1'b0, mag_att});
        else
            result <= sample_t'({1'b0, mag_att});
    end

endmodule

// ==== voice/fm_phase.sv ====
`timescale 1ns/1ps

module fm_phase (
    input  logic                            clk,
    input  logic                            reset,
    input  fm_pkg::slot_t                   op_sel,
    input  logic                            next,
    input  logic [fm_pkg::BLOCK_W-1:0]      block,
    input  logic [fm_pkg::FNUM_W-1:0]       fnum,
    input  logic [fm_pkg::MULT_W-1:0]       mult,
    output fm_pkg::phase_t                  phase
);
    import fm_pkg::*;

    logic [PH_ACC_W-1:0] acc_mem [NUM_SLOTS];
    logic [PH_ACC_W-1:0] acc;
    logic [16:0]         base;
    logic [20:0]         step;
    logic [6:0]          clr_cnt;
    logic                clearing;

    ////////////////////////////////////////
    // Clear sweep after reset
    ////////////////////////////////////////
    assign clearing = !clr_cnt[6];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clr_cnt <= '0;
        end else if (clearing) begin
            clr_cnt <= clr_cnt + 7'd1;
        end
    end

    ////////////////////////////////////////
    // Accumulator update
    ////////////////////////////////////////
    assign acc  = acc_mem[op_sel];
    assign base = 17'(fnum) << block;

    // mult 0 means one half
    assign step = (mult == '0) ? 21'(base >> 1) : 21'(base) * 21'(mult);

    always_ff @(posedge clk) begin
        if (clearing)
            acc_mem[clr_cnt[5:0]] <= '0;
        else if (next)
            acc_mem[op_sel] <= acc + step[PH_ACC_W-1:0];
    end

    // Entries not yet swept read as zero
    assign phase = clearing ? '0 : acc[PH_ACC_W-1 -: 10];

endmodule
